// File: dv/ahbLiteTb.sv
// Table-driven testbench for the AHB-Lite peripheral subsystem
`timescale 1ns/100ps

module ahbLiteTb;
    import ahbPkg::*;

    localparam int ramAddrWidth = 10;
    localparam int gpioWidth    = 16;
    localparam int loadValue    = 40;

    typedef struct {
        string       name;
        logic        write;
        hsize_e      size;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expData;
        hresp_e      expResp;
        int          expWaits;
    } stimEntry_t;

    logic                 HCLK;
    logic                 rst;
    logic [31:0]          HADDR;
    htrans_e              HTRANS;
    logic                 HWRITE;
    hsize_e               HSIZE;
    logic [3:0]           HPROT;
    logic                 HMASTLOCK;
    logic [31:0]          HWDATA;
    logic [31:0]          HRDATA;
    logic                 HREADY;
    hresp_e               HRESP;
    logic                 irq;
    logic [gpioWidth-1:0] gpioIn;
    logic [gpioWidth-1:0] gpioOut;
    logic [gpioWidth-1:0] gpioOe;

    stimEntry_t  stimTable[$];
    logic [31:0] ramModel [int];
    int          tableLen    = 0;
    int          cycleCount  = 0;
    int          dataErrors  = 0;
    int          respErrors  = 0;
    int          bitErrors   = 0;
    int          otherErrors = 0;

    ahbLite #(.ramAddrWidth(ramAddrWidth), .gpioWidth(gpioWidth)) i_dut (
        .HCLK(HCLK), .rst(rst), .HADDR(HADDR), .HTRANS(HTRANS), .HWRITE(HWRITE),
        .HSIZE(HSIZE), .HPROT(HPROT), .HMASTLOCK(HMASTLOCK), .HWDATA(HWDATA),
        .HRDATA(HRDATA), .HREADY(HREADY), .HRESP(HRESP), .irq(irq),
        .gpioIn(gpioIn), .gpioOut(gpioOut), .gpioOe(gpioOe)
    );

    initial begin
        HCLK = 1'b0;
        forever #20 HCLK = ~HCLK;
    end

    always @(posedge HCLK) cycleCount <= cycleCount + 1;

    // Budget scales with the table, plus room for timer polling
    initial begin
        wait (tableLen > 0);
        repeat (tableLen * 20 + 2000) @(posedge HCLK);
        $display("Timeout: the run did not finish within %0d cycles", tableLen * 20 + 2000);
        $display("Test failures found");
        $finish;
    end

    task automatic checkData(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            dataErrors++;
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic checkResp(input string name, input hresp_e expected, input hresp_e actual);
        if (actual !== expected) begin
            respErrors++;
            $display("[ERROR] %s: expected %s, actual %s", name, expected.name(), actual.name());
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            bitErrors++;
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic checkOeBits(input string name, input logic [gpioWidth-1:0] expected);
        for (int i = 0; i < gpioWidth; i++) begin
            checkBit($sformatf("%s[%0d]", name, i), expected[i], gpioOe[i]);
        end
    endtask

    // Single transfer, starts and ends 2 ns after a rising edge
    task automatic busTransfer(input logic write, input hsize_e size, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output hresp_e resp, output int waits);
        waits  = 0;
        HADDR  = addr;
        HTRANS = NONSEQ;
        HWRITE = write;
        HSIZE  = size;
        @(negedge HCLK);
        while (!HREADY) @(negedge HCLK);
        @(posedge HCLK);
        #2;
        HTRANS = IDLE;
        HWDATA = write ? wdata : 32'h0;
        @(negedge HCLK);
        while (!HREADY) begin
            waits++;
            @(negedge HCLK);
        end
        rdata = HRDATA;
        resp  = HRESP;
        @(posedge HCLK);
        #2;
    endtask

    // Little-endian lane merge for BYTE, HALF and WORD writes
    function automatic logic [31:0] mergeLanes(input logic [31:0] oldWord,
                                               input logic [31:0] wdata,
                                               input hsize_e size, input logic [1:0] offset);
        logic [31:0] word;
        logic        hit;
        word = oldWord;
        for (int b = 0; b < 4; b++) begin
            hit = (size == WORD) || (size == HALF && (b / 2) == int'(offset[1]))
                  || (size == BYTE && b == int'(offset));
            if (hit) begin
                word[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return word;
    endfunction

    task automatic addEntry(input string name, input logic write, input hsize_e size,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [31:0] expData, input hresp_e expResp,
                            input int expWaits);
        stimEntry_t e;
        e.name     = name;
        e.write    = write;
        e.size     = size;
        e.addr     = addr;
        e.wdata    = wdata;
        e.expData  = expData;
        e.expResp  = expResp;
        e.expWaits = expWaits;
        stimTable.push_back(e);
    endtask

    task automatic ramWrite(input string name, input hsize_e size, input logic [31:0] addr,
                            input logic [31:0] wdata);
        int idx;
        idx = int'(addr[ramAddrWidth+1:2]);
        ramModel[idx] = mergeLanes(ramModel[idx], wdata, size, addr[1:0]);
        addEntry(name, 1'b1, size, addr, wdata, 32'h0, OKAY, 0);
    endtask

    task automatic ramRead(input string name, input logic [31:0] addr);
        addEntry(name, 1'b0, WORD, addr, 32'h0, ramModel[int'(addr[ramAddrWidth+1:2])], OKAY, 0);
    endtask

    task automatic buildTable();
        // Full words first so partial writes merge into known data
        ramWrite("ramWordWr0", WORD, 32'h0000_0000, $urandom());
        ramWrite("ramWordWr1", WORD, 32'h0000_0004, $urandom());
        ramWrite("ramWordWr2", WORD, 32'h0000_0100, $urandom());
        ramWrite("ramWordWr3", WORD, 32'h0000_0FFC, $urandom());
        ramRead("ramWordRd0", 32'h0000_0000);
        ramRead("ramWordRd1", 32'h0000_0004);
        ramRead("ramWordRd2", 32'h0000_0100);
        ramRead("ramWordRd3", 32'h0000_0FFC);
        ramWrite("ramByteWrLane1", BYTE, 32'h0000_0005, $urandom());
        ramWrite("ramByteWrLane3", BYTE, 32'h0000_0103, $urandom());
        ramWrite("ramHalfWrUpper", HALF, 32'h0000_0006, $urandom());
        ramWrite("ramHalfWrLower", HALF, 32'h0000_0FFC, $urandom());
        ramRead("ramMergeRd1", 32'h0000_0004);
        ramRead("ramMergeRd2", 32'h0000_0100);
        ramRead("ramMergeRd3", 32'h0000_0FFC);
        addEntry("gpioDirWr", 1'b1, WORD, gpioBase + 32'h4, 32'hABCD_F0F0, 32'h0, OKAY, 0);
        addEntry("gpioOutWr", 1'b1, WORD, gpioBase, 32'h1234_5A3C, 32'h0, OKAY, 0);
        addEntry("gpioDirRd", 1'b0, WORD, gpioBase + 32'h4, 32'h0, 32'h0000_F0F0, OKAY, 0);
        addEntry("gpioOutRd", 1'b0, WORD, gpioBase, 32'h0, 32'h0000_5A3C, OKAY, 0);
        // IN is read only, pins still low
        addEntry("gpioInWr", 1'b1, WORD, gpioBase + 32'h8, 32'hFFFF_FFFF, 32'h0, OKAY, 0);
        addEntry("gpioInRd", 1'b0, WORD, gpioBase + 32'h8, 32'h0, 32'h0, OKAY, 0);
        addEntry("unmappedRd", 1'b0, WORD, 32'h8000_0000, 32'h0, 32'h0, ERROR, 1);
        ramRead("ramAfterErrRd", 32'h0000_0000);
        addEntry("unmappedWr", 1'b1, WORD, 32'h8000_0010, 32'h5555_AAAA, 32'h0, ERROR, 1);
        ramRead("ramAfterErrWr", 32'h0000_0100);
    endtask

    task automatic applyTable();
        stimEntry_t  e;
        logic [31:0] rdata;
        hresp_e      resp;
        int          waits;
        foreach (stimTable[i]) begin
            e = stimTable[i];
            busTransfer(e.write, e.size, e.addr, e.wdata, rdata, resp, waits);
            checkResp(e.name, e.expResp, resp);
            checkData({e.name, "Waits"}, 32'(e.expWaits), 32'(waits));
            if (!e.write && e.expResp == OKAY) begin
                checkData(e.name, e.expData, rdata);
            end
        end
    endtask

    task automatic timerTest();
        logic [31:0] rdata;
        hresp_e      resp;
        int          waits;
        int          startCycle;
        busTransfer(1'b1, WORD, timerBase, 32'(loadValue), rdata, resp, waits);
        checkResp("timerLoadWr", OKAY, resp);
        // Enable plus irqEn
        busTransfer(1'b1, WORD, timerBase + 32'h8, 32'h3, rdata, resp, waits);
        startCycle = cycleCount;
        rdata      = 32'h0;
        while (rdata[0] !== 1'b1 && (cycleCount - startCycle) <= loadValue + 10) begin
            busTransfer(1'b0, WORD, timerBase + 32'hC, 32'h0, rdata, resp, waits);
        end
        if (rdata[0] !== 1'b1) begin
            otherErrors++;
            $display("Timer flag was not set within %0d cycles of enabling", loadValue + 10);
        end
        checkBit("timerIrqSet", 1'b1, irq);
        // Stop counting so the flag cannot come back
        busTransfer(1'b1, WORD, timerBase + 32'h8, 32'h2, rdata, resp, waits);
        checkBit("timerIrqHeld", 1'b1, irq);
        busTransfer(1'b1, WORD, timerBase + 32'hC, 32'h1, rdata, resp, waits);
        checkBit("timerIrqCleared", 1'b0, irq);
        busTransfer(1'b0, WORD, timerBase + 32'hC, 32'h0, rdata, resp, waits);
        checkData("timerStatusCleared", 32'h0, rdata);
    endtask

    initial begin
        logic [31:0] rdata;
        hresp_e      resp;
        int          waits;
        rst       = 1'b1;
        HADDR     = 32'h0;
        HTRANS    = IDLE;
        HWRITE    = 1'b0;
        HSIZE     = WORD;
        HPROT     = 4'b0011;
        HMASTLOCK = 1'b0;
        HWDATA    = 32'h0;
        gpioIn    = '0;
        void'($urandom(32'h3c8d_6700));
        repeat (10) @(posedge HCLK);
        #2;
        rst = 1'b0;
        checkBit("resetHready", 1'b1, HREADY);
        checkResp("resetHresp", OKAY, HRESP);
        checkBit("resetIrq", 1'b0, irq);
        checkOeBits("resetGpioOe", '0);
        buildTable();
        tableLen = stimTable.size();
        applyTable();
        checkOeBits("gpioOe", 16'hF0F0);
        checkData("gpioOut", 32'h0000_5A3C, 32'(gpioOut));
        // Pins need two synchronizer cycles
        gpioIn = 16'h3C96;
        repeat (3) @(posedge HCLK);
        #2;
        busTransfer(1'b0, WORD, gpioBase + 32'h8, 32'h0, rdata, resp, waits);
        checkData("gpioInPins", 32'h0000_3C96, rdata);
        timerTest();
        $display("Errors: data %0d, resp %0d, bit %0d, other %0d",
                 dataErrors, respErrors, bitErrors, otherErrors);
        if (dataErrors + respErrors + bitErrors + otherErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: hdl/ahbBlockRam.sv
// AHB-Lite zero-wait-state word RAM with byte and halfword writes
`timescale 1ns/100ps

module ahbBlockRam #(
    parameter int ramAddrWidth = 10
) (
    input  logic             HCLK,
    input  logic             rst,
    input  ahbPkg::ahbCtrl_t busCtrl,
    input  logic [31:0]      HWDATA,
    input  logic             HREADY,
    output ahbPkg::ahbResp_t resp
);
    import ahbPkg::*;

    logic [31:0]             mem [2**ramAddrWidth];
    logic                    addrAccept;
    logic [3:0]              laneMask;
    logic                    dataWrite;
    logic [ramAddrWidth-1:0] dataAddr;
    logic [3:0]              dataLanes;

    assign addrAccept = busCtrl.hsel && HREADY && transActive(busCtrl.htrans);

    // Byte lanes touched by the transfer, little endian
    always_comb begin
        case (busCtrl.hsize)
            BYTE:    laneMask = 4'b0001 << busCtrl.haddr[1:0];
            HALF:    laneMask = busCtrl.haddr[1] ? 4'b1100 : 4'b0011;
            default: laneMask = 4'b1111;
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (rst) begin
            dataWrite <= 1'b0;
        end else if (HREADY) begin
            dataWrite <= addrAccept && busCtrl.hwrite;
        end
    end

    // Word address and lanes held until the data phase
    always_ff @(posedge HCLK) begin
        if (addrAccept) begin
            dataAddr  <= busCtrl.haddr[ramAddrWidth+1:2];
            dataLanes <= laneMask;
        end
    end

    always_ff @(posedge HCLK) begin
        if (dataWrite && HREADY) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (dataLanes[lane]) begin
                    mem[dataAddr][lane*8 +: 8] <= HWDATA[lane*8 +: 8];
                end
            end
        end
    end

    // Reads return the whole word in the data phase
    assign resp = '{
        hrdata:    mem[dataAddr],
        hreadyout: 1'b1,
        hresp:     OKAY
    };

endmodule

// File: hdl/ahbDecoder.sv
// AHB-Lite address decoder, turns HADDR into one-hot slave selects
`timescale 1ns/100ps

module ahbDecoder (
    input  logic [31:0]                  HADDR,
    output logic [ahbPkg::numSlaves-1:0] hselVec
);
    import ahbPkg::*;

    logic [3:0] region;
    logic [3:0] page;

    assign region = HADDR[31:28];
    assign page   = HADDR[15:12];

    always_comb begin
        hselVec = '0;
        if (region == ramBase[31:28]) begin
            hselVec[RAM] = 1'b1;
        end else if (region == gpioBase[31:28]) begin
            // Peripheral region, pick the 4 KB page
            if (page == gpioBase[15:12]) begin
                hselVec[GPIO] = 1'b1;
            end else if (page == timerBase[15:12]) begin
                hselVec[TIMER] = 1'b1;
            end
        end
        // Anything else leaves all selects low for the default slave
    end

endmodule

// File: hdl/ahbGpio.sv
// AHB-Lite GPIO block with output, direction and synchronized input registers
`timescale 1ns/100ps

module ahbGpio #(
    parameter int gpioWidth = 16
) (
    input  logic                 HCLK,
    input  logic                 rst,
    input  ahbPkg::ahbCtrl_t     busCtrl,
    input  logic [31:0]          HWDATA,
    input  logic                 HREADY,
    output ahbPkg::ahbResp_t     resp,
    input  logic [gpioWidth-1:0] gpioIn,
    output logic [gpioWidth-1:0] gpioOut,
    output logic [gpioWidth-1:0] gpioOe
);
    import ahbPkg::*;

    logic                 addrAccept;
    logic                 dataWrite;
    gpioReg_e             dataReg;
    logic                 wrEn;
    logic [gpioWidth-1:0] outReg;
    logic [gpioWidth-1:0] dirReg;
    logic [gpioWidth-1:0] inSync1;
    logic [gpioWidth-1:0] inSync2;
    logic [31:0]          rdata;

    assign addrAccept = busCtrl.hsel && HREADY && transActive(busCtrl.htrans);
    assign wrEn       = dataWrite && HREADY;

    always_ff @(posedge HCLK) begin
        if (rst) begin
            dataWrite <= 1'b0;
        end else if (HREADY) begin
            dataWrite <= addrAccept && busCtrl.hwrite;
        end
    end

    always_ff @(posedge HCLK) begin
        if (addrAccept) begin
            dataReg <= gpioReg_e'(busCtrl.haddr[3:0]);
        end
    end

    always_ff @(posedge HCLK) begin
        if (rst) begin
            outReg <= '0;
            dirReg <= '0;
        end else if (wrEn) begin
            case (dataReg)
                OUT:     outReg <= HWDATA[gpioWidth-1:0];
                DIR:     dirReg <= HWDATA[gpioWidth-1:0];
                default: ;
            endcase
        end
    end

    // Two-flop synchronizer on the pins
    always_ff @(posedge HCLK) begin
        if (rst) begin
            inSync1 <= '0;
            inSync2 <= '0;
        end else begin
            inSync1 <= gpioIn;
            inSync2 <= inSync1;
        end
    end

    always_comb begin
        rdata = '0;
        case (dataReg)
            OUT:     rdata[gpioWidth-1:0] = outReg;
            DIR:     rdata[gpioWidth-1:0] = dirReg;
            IN:      rdata[gpioWidth-1:0] = inSync2;
            default: rdata = '0;
        endcase
    end

    assign resp    = '{hrdata: rdata, hreadyout: 1'b1, hresp: OKAY};
    assign gpioOut = outReg;
    assign gpioOe  = dirReg;

endmodule

// File: hdl/ahbLite.sv
// AHB-Lite peripheral subsystem with decoder, response mux, RAM, GPIO and timer
`timescale 1ns/100ps

module ahbLite #(
    parameter int ramAddrWidth = 10,
    parameter int gpioWidth    = 16
) (
    input  logic                 HCLK,
    input  logic                 rst,
    input  logic [31:0]          HADDR,
    input  ahbPkg::htrans_e      HTRANS,
    input  logic                 HWRITE,
    input  ahbPkg::hsize_e       HSIZE,
    input  logic [3:0]           HPROT,
    input  logic                 HMASTLOCK,
    input  logic [31:0]          HWDATA,
    output logic [31:0]          HRDATA,
    output logic                 HREADY,
    output ahbPkg::hresp_e       HRESP,
    output logic                 irq,
    input  logic [gpioWidth-1:0] gpioIn,
    output logic [gpioWidth-1:0] gpioOut,
    output logic [gpioWidth-1:0] gpioOe
);
    import ahbPkg::*;

    // HPROT and HMASTLOCK have no effect on these slaves
    ahbCtrl_t                   busCtrl;
    logic [numSlaves-1:0]       hselVec;
    ahbCtrl_t                   slaveCtrl [numSlaves];
    ahbResp_t [numSlaves-1:0]   slaveResp;

    assign busCtrl = '{haddr: HADDR, htrans: HTRANS, hwrite: HWRITE, hsize: HSIZE, hsel: 1'b0};

    // Per-slave copy of the request with its own select
    for (genvar i = 0; i < numSlaves; i++) begin : gSlaveCtrl
        assign slaveCtrl[i] = '{busCtrl.haddr, busCtrl.htrans, busCtrl.hwrite,
                                busCtrl.hsize, hselVec[i]};
    end

    ahbDecoder uDecoder (
        .HADDR(HADDR),
        .hselVec(hselVec)
    );

    ahbSlaveMux uSlaveMux (
        .HCLK(HCLK),
        .rst(rst),
        .busCtrl(busCtrl),
        .hselVec(hselVec),
        .slaveResp(slaveResp),
        .HREADY(HREADY),
        .HRESP(HRESP),
        .HRDATA(HRDATA)
    );

    ahbBlockRam #(.ramAddrWidth(ramAddrWidth)) uBlockRam (
        .HCLK(HCLK),
        .rst(rst),
        .busCtrl(slaveCtrl[RAM]),
        .HWDATA(HWDATA),
        .HREADY(HREADY),
        .resp(slaveResp[RAM])
    );

    ahbGpio #(.gpioWidth(gpioWidth)) uGpio (
        .HCLK(HCLK),
        .rst(rst),
        .busCtrl(slaveCtrl[GPIO]),
        .HWDATA(HWDATA),
        .HREADY(HREADY),
        .resp(slaveResp[GPIO]),
        .gpioIn(gpioIn),
        .gpioOut(gpioOut),
        .gpioOe(gpioOe)
    );

    ahbTimer uTimer (
        .HCLK(HCLK),
        .rst(rst),
        .busCtrl(slaveCtrl[TIMER]),
        .HWDATA(HWDATA),
        .HREADY(HREADY),
        .resp(slaveResp[TIMER]),
        .irq(irq)
    );

endmodule

// File: hdl/ahbPkg.sv
// AHB-Lite bus types, address map and register offsets for the peripheral subsystem
package ahbPkg;

    // Transfer type on HTRANS
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_e;

    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_e;

    localparam int numSlaves = 3;

    // Index into select and response vectors
    typedef enum logic [1:0] {
        RAM   = 2'd0,
        GPIO  = 2'd1,
        TIMER = 2'd2
    } slaveId_e;

    // Address map, region in [31:28], page in [15:12]
    localparam logic [31:0] ramBase   = 32'h0000_0000;
    localparam logic [31:0] gpioBase  = 32'h4000_0000;
    localparam logic [31:0] timerBase = 32'h4000_1000;

    // Address-phase request as seen by one slave
    typedef struct packed {
        logic [31:0] haddr;
        htrans_e     htrans;
        logic        hwrite;
        hsize_e      hsize;
        logic        hsel;
    } ahbCtrl_t;

    // Data-phase response of one slave
    typedef struct packed {
        logic [31:0] hrdata;
        logic        hreadyout;
        hresp_e      hresp;
    } ahbResp_t;

    typedef enum logic [3:0] {
        LOAD   = 4'h0,
        VALUE  = 4'h4,
        CTRL   = 4'h8,
        STATUS = 4'hC
    } timerReg_e;

    typedef enum logic [3:0] {
        OUT = 4'h0,
        DIR = 4'h4,
        IN  = 4'h8
    } gpioReg_e;

    // NONSEQ and SEQ carry data, IDLE and BUSY do not
    function automatic logic transActive(input htrans_e htrans);
        return (htrans == NONSEQ) || (htrans == SEQ);
    endfunction

endpackage

// File: hdl/ahbSlaveMux.sv
// AHB-Lite data-phase response multiplexer with default error slave
`timescale 1ns/100ps

module ahbSlaveMux (
    input  logic                                      HCLK,
    input  logic                                      rst,
    input  ahbPkg::ahbCtrl_t                          busCtrl,
    input  logic [ahbPkg::numSlaves-1:0]              hselVec,
    input  ahbPkg::ahbResp_t [ahbPkg::numSlaves-1:0]  slaveResp,
    output logic                                      HREADY,
    output ahbPkg::hresp_e                            HRESP,
    output logic [31:0]                               HRDATA
);
    import ahbPkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ERR1,
        ST_ERR2
    } errState_e;

    errState_e errState;
    errState_e errNext;
    logic      addrPhase;
    logic      addrHit;
    slaveId_e  addrSlave;
    logic      dataHit;
    slaveId_e  dataSlave;

    // Address phase accepted this cycle
    assign addrPhase = HREADY && transActive(busCtrl.htrans);
    assign addrHit   = |hselVec;

    // One-hot to slave index
    always_comb begin
        addrSlave = RAM;
        for (int i = 0; i < numSlaves; i++) begin
            if (hselVec[i]) begin
                addrSlave = slaveId_e'(i);
            end
        end
    end

    always_comb begin
        if (addrPhase && !addrHit) begin
            errNext = ST_ERR1;
        end else if (errState == ST_ERR1) begin
            errNext = ST_ERR2;
        end else begin
            errNext = ST_IDLE;
        end
    end

    always_ff @(posedge HCLK) begin
        if (rst) begin
            errState  <= ST_IDLE;
            dataHit   <= 1'b0;
            dataSlave <= RAM;
        end else begin
            errState <= errNext;
            if (HREADY) begin
                dataHit   <= addrPhase && addrHit;
                dataSlave <= addrSlave;
            end
        end
    end

    // Two-cycle ERROR, then the selected slave, else an idle OKAY
    always_comb begin
        HREADY = 1'b1;
        HRESP  = OKAY;
        HRDATA = '0;
        case (errState)
            ST_ERR1: begin
                HREADY = 1'b0;
                HRESP  = ERROR;
            end
            ST_ERR2: HRESP = ERROR;
            default: begin
                if (dataHit) begin
                    HREADY = slaveResp[dataSlave].hreadyout;
                    HRESP  = slaveResp[dataSlave].hresp;
                    HRDATA = slaveResp[dataSlave].hrdata;
                end
            end
        endcase
    end

endmodule

// File: hdl/ahbTimer.sv
// AHB-Lite reloading down-counter timer with status flag and interrupt
`timescale 1ns/100ps

module ahbTimer (
    input  logic             HCLK,
    input  logic             rst,
    input  ahbPkg::ahbCtrl_t busCtrl,
    input  logic [31:0]      HWDATA,
    input  logic             HREADY,
    output ahbPkg::ahbResp_t resp,
    output logic             irq
);
    import ahbPkg::*;

    // CTRL bit 1 is irqEn, bit 0 is enable
    typedef struct packed {
        logic irqEn;
        logic enable;
    } timerCtrl_t;

    logic        addrAccept;
    logic        dataWrite;
    timerReg_e   dataReg;
    logic        wrEn;
    logic        reload;
    logic        statusClear;
    logic [31:0] loadReg;
    logic [31:0] valueReg;
    timerCtrl_t  ctrlReg;
    logic        flag;
    logic [31:0] rdata;

    assign addrAccept  = busCtrl.hsel && HREADY && transActive(busCtrl.htrans);
    assign wrEn        = dataWrite && HREADY;
    assign reload      = ctrlReg.enable && (valueReg == '0);
    assign statusClear = wrEn && (dataReg == STATUS) && HWDATA[0];

    always_ff @(posedge HCLK) begin
        if (rst) begin
            dataWrite <= 1'b0;
        end else if (HREADY) begin
            dataWrite <= addrAccept && busCtrl.hwrite;
        end
    end

    always_ff @(posedge HCLK) begin
        if (addrAccept) begin
            dataReg <= timerReg_e'(busCtrl.haddr[3:0]);
        end
    end

    always_ff @(posedge HCLK) begin
        if (rst) begin
            loadReg <= '0;
            ctrlReg <= '0;
        end else if (wrEn) begin
            case (dataReg)
                LOAD:    loadReg <= HWDATA;
                CTRL:    ctrlReg <= timerCtrl_t'(HWDATA[1:0]);
                default: ;
            endcase
        end
    end

    // Bus write of LOAD takes priority over counting
    always_ff @(posedge HCLK) begin
        if (rst) begin
            valueReg <= '0;
        end else if (wrEn && (dataReg == LOAD)) begin
            valueReg <= HWDATA;
        end else if (ctrlReg.enable) begin
            valueReg <= reload ? loadReg : valueReg - 32'd1;
        end
    end

    // A reload in the same cycle beats a clear
    always_ff @(posedge HCLK) begin
        if (rst) begin
            flag <= 1'b0;
        end else if (reload) begin
            flag <= 1'b1;
        end else if (statusClear) begin
            flag <= 1'b0;
        end
    end

    always_comb begin
        case (dataReg)
            LOAD:    rdata = loadReg;
            VALUE:   rdata = valueReg;
            CTRL:    rdata = {30'd0, ctrlReg};
            STATUS:  rdata = {31'd0, flag};
            default: rdata = '0;
        endcase
    end

    assign resp = '{hrdata: rdata, hreadyout: 1'b1, hresp: OKAY};
    assign irq  = flag && ctrlReg.irqEn;

endmodule

// File: run.sh
#!/bin/sh
# Builds the AHB-Lite testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module ahbLiteTb -f sim.f -o ahbLiteSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ahbLiteSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: sim.f
hdl/ahbPkg.sv
hdl/ahbDecoder.sv
hdl/ahbSlaveMux.sv
hdl/ahbBlockRam.sv
hdl/ahbGpio.sv
hdl/ahbTimer.sv
hdl/ahbLite.sv
dv/ahbLiteTb.sv
